// ==== Makefile ====
SIM    = verilator
FLAGS  = --binary --timing
TOP    = ex_stage_tb
FLIST  = list.f
LOG    = sim.log
OBJDIR = obj_dir

.PHONY: run build lint clean

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== include/ex_defs.svh ====
/* execute stage sizes, RV32 only
   MULT_STEPS must divide XLEN evenly
   immediate macros take a plain 32-bit instruction word (an identifier, not an expression) */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

////////////////////////////////////////////////////
// widths and counts
////////////////////////////////////////////////////
`define XLEN        32  // data path width
`define WAYS        2   // independent execute ways
`define MULT_STEPS  4   // multiplier iterations
`define ROB_IDX_W   5   // 32-entry rob
`define PRF_IDX_W   6   // 64 physical registers

////////////////////////////////////////////////////
// immediates, sign-extended to 32 bits
////////////////////////////////////////////////////
`define SEXT_I_IMM(inst) {{21{inst[31]}}, inst[30:20]}
`define SEXT_S_IMM(inst) {{21{inst[31]}}, inst[30:25], inst[11:7]}
`define SEXT_B_IMM(inst) {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0}
`define SEXT_U_IMM(inst) {inst[31:12], 12'b0}
`define SEXT_J_IMM(inst) {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}

`endif

// ==== list.f ====
+incdir+include
src/isa_pkg.sv
src/pipe_pkg.sv
src/mult.sv
src/alu.sv
src/brcond.sv
src/ex_stage.sv
verification/ex_checker.sv
verification/ex_stage_tb.sv

// ==== src/alu.sv ====
/* one execute way: base ops complete one cycle after acceptance,
   multiplies hold occupied until their result is presented
   valid_in is ignored while occupied */
`timescale 1ns/100ps
`include "ex_defs.svh"

module alu (
	input  logic                clock,
	input  logic                reset,
	input  logic                valid_in,
	input  logic [`XLEN-1:0]    opa,
	input  logic [`XLEN-1:0]    opb,
	input  isa_pkg::alu_func_e  func,
	output logic                occupied,
	output logic                valid_out,
	output logic [`XLEN-1:0]    result
);
	import isa_pkg::*;

	typedef enum logic [2:0] {IDLE, START, BUSY, DONE, BASE_DONE} alu_state_e;

	alu_state_e         state;
	alu_state_e         next_state;
	logic               accept;
	logic               is_mult;
	logic               start;
	logic               mult_done;
	logic               high_half;     // decoded, current func
	logic               high_half_q;   // held for the running multiply
	logic [1:0]         sign;
	logic [`XLEN-1:0]   base_value;
	logic [`XLEN-1:0]   base_q;
	logic [2*`XLEN-1:0] product;

	assign occupied  = (state == START) || (state == BUSY);
	assign valid_out = (state == DONE) || (state == BASE_DONE);
	assign accept    = valid_in && !occupied;
	assign start     = accept && is_mult;   // mult samples opa/opb this edge

	mult mult_inst (
		.clock   (clock),
		.reset   (reset),
		.start   (start),
		.sign    (sign),
		.mcand   (opa),
		.mplier  (opb),
		.product (product),
		.done    (mult_done)
	);

	////////////////////////////////////////////////////
	// function decode and base results
	////////////////////////////////////////////////////
	always_comb begin
		base_value = '0;
		is_mult    = 1'b0;
		sign       = 2'b00;
		high_half  = 1'b0;
		case (func)
			ALU_ADD:  base_value = opa + opb;
			ALU_SUB:  base_value = opa - opb;
			ALU_SLT:  base_value = {{(`XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
			ALU_SLTU: base_value = {{(`XLEN-1){1'b0}}, opa < opb};
			ALU_AND:  base_value = opa & opb;
			ALU_OR:   base_value = opa | opb;
			ALU_XOR:  base_value = opa ^ opb;
			ALU_SLL:  base_value = opa << opb[4:0];  // shamt from low 5 bits
			ALU_SRL:  base_value = opa >> opb[4:0];
			ALU_SRA:  base_value = $signed(opa) >>> opb[4:0];
			ALU_MUL: begin
				is_mult = 1'b1;
				sign    = 2'b11;   // low half same for any signedness
			end
			ALU_MULH: begin
				is_mult   = 1'b1;
				sign      = 2'b11;
				high_half = 1'b1;
			end
			ALU_MULHSU: begin
				is_mult   = 1'b1;
				sign      = 2'b10;   // rs1 signed, rs2 unsigned
				high_half = 1'b1;
			end
			ALU_MULHU: begin
				is_mult   = 1'b1;
				high_half = 1'b1;
			end
			default: base_value = '0;
		endcase
	end

	// next state, a new op may start in any finishing state
	always_comb begin
		next_state = state;
		case (state)
			START: next_state = BUSY;
			BUSY:  if (mult_done) next_state = DONE;
			default: begin  // IDLE, DONE, BASE_DONE
				if (!accept)      next_state = IDLE;
				else if (is_mult) next_state = START;
				else              next_state = BASE_DONE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) state <= IDLE;
		else       state <= next_state;
	end

	always_ff @(posedge clock) begin
		if (accept && !is_mult) base_q <= base_value;
		if (start)              high_half_q <= high_half;
	end

	assign result = (state != DONE) ? base_q :
		high_half_q ? product[2*`XLEN-1:`XLEN] : product[`XLEN-1:0];

endmodule

// ==== src/brcond.sv ====
/* branch condition from funct3, purely combinational
   funct3 values 010 and 011 are not branches and give false */
`timescale 1ns/100ps
`include "ex_defs.svh"

module brcond (
	input  logic [`XLEN-1:0]  rs1,
	input  logic [`XLEN-1:0]  rs2,
	input  isa_pkg::br_func_e func,
	output logic              cond
);
	import isa_pkg::*;

	logic equal;
	logic less_s;
	logic less_u;

	assign equal  = (rs1 == rs2);
	assign less_s = $signed(rs1) < $signed(rs2);
	assign less_u = rs1 < rs2;

	always_comb begin
		case (func)
			BR_EQ:   cond = equal;
			BR_NE:   cond = !equal;
			BR_LT:   cond = less_s;
			BR_GE:   cond = !less_s;   // ge is not lt
			BR_LTU:  cond = less_u;
			BR_GEU:  cond = !less_u;
			default: cond = 1'b0;
		endcase
	end

endmodule

// ==== src/ex_stage.sv ====
/* two-way execute stage; each way accepts one packet when not occupied
   completions are registered and stay in issue order within a way
   the memory side must take every completion, there is no stall input */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage (
	input  logic                                 clock,
	input  logic                                 reset,
	input  pipe_pkg::id_ex_packet_t  [`WAYS-1:0] id_ex_packet_in,
	output pipe_pkg::ex_mem_packet_t [`WAYS-1:0] ex_packet_out,
	output logic [`WAYS-1:0]                     occupied
);
	import isa_pkg::*;
	import pipe_pkg::*;

	for (genvar i = 0; i < `WAYS; i++) begin : g_way
		id_ex_packet_t         pkt;
		logic [31:0]           inst_word;   // flat view for the immediate macros
		logic [`XLEN-1:0]      opa;
		logic [`XLEN-1:0]      opb;
		logic                  accept;
		logic                  cond;
		logic                  alu_valid;
		logic [`XLEN-1:0]      alu_result;
		// fields held from acceptance to completion
		logic                  take_branch_q;
		logic [`XLEN-1:0]      npc_q;
		logic [`XLEN-1:0]      rs2_value_q;
		logic                  rd_mem_q;
		logic                  wr_mem_q;
		logic [2:0]            mem_size_q;
		logic                  csr_op_q;
		logic                  halt_q;
		logic                  illegal_q;
		logic [`PRF_IDX_W-1:0] dest_prf_idx_q;
		logic [`ROB_IDX_W-1:0] rob_idx_q;

		assign pkt       = id_ex_packet_in[i];
		assign inst_word = pkt.inst;
		assign accept    = pkt.valid && !occupied[i];  // drop anything shown while busy

		////////////////////////////////////////////////////
		// operand muxes
		////////////////////////////////////////////////////
		always_comb begin
			case (pkt.opa_select)
				OPA_IS_RS1: opa = pkt.rs1_value;
				OPA_IS_NPC: opa = pkt.NPC;
				OPA_IS_PC:  opa = pkt.PC;
				default:    opa = '0;   // OPA_IS_ZERO, lui
			endcase
		end

		always_comb begin
			case (pkt.opb_select)
				OPB_IS_RS2:   opb = pkt.rs2_value;
				OPB_IS_I_IMM: opb = `SEXT_I_IMM(inst_word);
				OPB_IS_S_IMM: opb = `SEXT_S_IMM(inst_word);
				OPB_IS_B_IMM: opb = `SEXT_B_IMM(inst_word);
				OPB_IS_U_IMM: opb = `SEXT_U_IMM(inst_word);
				OPB_IS_J_IMM: opb = `SEXT_J_IMM(inst_word);
				default:      opb = '0;   // unused codes
			endcase
		end

		alu alu_inst (
			.clock     (clock),
			.reset     (reset),
			.valid_in  (accept),
			.opa       (opa),
			.opb       (opb),
			.func      (pkt.alu_func),
			.occupied  (occupied[i]),
			.valid_out (alu_valid),
			.result    (alu_result)
		);

		// compares the raw register values, not the muxed operands
		brcond brcond_inst (
			.rs1  (pkt.rs1_value),
			.rs2  (pkt.rs2_value),
			.func (pkt.inst.b.funct3),
			.cond (cond)
		);

		////////////////////////////////////////////////////
		// pass-through register, loaded on acceptance
		////////////////////////////////////////////////////
		always_ff @(posedge clock) begin
			if (accept) begin
				take_branch_q  <= pkt.uncond_branch || (pkt.cond_branch && cond);
				npc_q          <= pkt.NPC;
				rs2_value_q    <= pkt.rs2_value;
				rd_mem_q       <= pkt.rd_mem;
				wr_mem_q       <= pkt.wr_mem;
				mem_size_q     <= pkt.inst.r.funct3;
				csr_op_q       <= pkt.csr_op;
				halt_q         <= pkt.halt;
				illegal_q      <= pkt.illegal;
				dest_prf_idx_q <= pkt.dest_prf_idx;
				rob_idx_q      <= pkt.rob_idx;
			end
		end

		assign ex_packet_out[i] = '{
			valid:        alu_valid,
			alu_result:   alu_result,
			take_branch:  take_branch_q,
			NPC:          npc_q,
			rs2_value:    rs2_value_q,
			rd_mem:       rd_mem_q,
			wr_mem:       wr_mem_q,
			mem_size:     mem_size_q,
			csr_op:       csr_op_q,
			halt:         halt_q,
			illegal:      illegal_q,
			dest_prf_idx: dest_prf_idx_q,
			rob_idx:      rob_idx_q
		};
	end

endmodule

// ==== src/isa_pkg.sv ====
/* instruction level types for the execute stage
   enum values are fixed, pattern files encode them directly */
package isa_pkg;

	// alu function codes, base ops first then the M multiplies
	typedef enum logic [3:0] {
		ALU_ADD    = 4'h0,
		ALU_SUB    = 4'h1,
		ALU_SLT    = 4'h2,
		ALU_SLTU   = 4'h3,
		ALU_AND    = 4'h4,
		ALU_OR     = 4'h5,
		ALU_XOR    = 4'h6,
		ALU_SLL    = 4'h7,
		ALU_SRL    = 4'h8,
		ALU_SRA    = 4'h9,
		ALU_MUL    = 4'ha,
		ALU_MULH   = 4'hb,
		ALU_MULHSU = 4'hc,
		ALU_MULHU  = 4'hd
	} alu_func_e;

	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_NPC  = 2'h1,
		OPA_IS_PC   = 2'h2,
		OPA_IS_ZERO = 2'h3
	} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'h0,
		OPB_IS_I_IMM = 3'h1,
		OPB_IS_S_IMM = 3'h2,
		OPB_IS_B_IMM = 3'h3,
		OPB_IS_U_IMM = 3'h4,
		OPB_IS_J_IMM = 3'h5  // 6 and 7 unused
	} opb_sel_e;

	// funct3 of the branch opcode
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} br_func_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;   // also the load/store size
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		br_func_e   funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_type_t;

	typedef union packed {
		r_type_t r;
		b_type_t b;
	} inst_t;

endpackage

// ==== src/mult.sv ====
/* iterative 32x32 -> 64 multiplier, XLEN/MULT_STEPS multiplier bits per cycle
   raise start only while idle; operands are sampled on that edge only
   product holds after done until the next start */
`timescale 1ns/100ps
`include "ex_defs.svh"

module mult (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  logic [1:0]          sign,    // [1] mcand signed, [0] mplier signed
	input  logic [`XLEN-1:0]    mcand,
	input  logic [`XLEN-1:0]    mplier,
	output logic [2*`XLEN-1:0]  product,
	output logic                done
);
	localparam int STEP_W = `XLEN / `MULT_STEPS;    // bits retired per step
	localparam int CNT_W  = $clog2(`MULT_STEPS + 1);

	logic [2*`XLEN-1:0] mcand_q;     // moves left by STEP_W each step
	logic [2*`XLEN-1:0] mplier_q;    // moves right, keeps its extension
	logic [2*`XLEN-1:0] acc;
	logic [2*`XLEN-1:0] partial;
	logic [2*`XLEN-1:0] correction;
	logic [CNT_W-1:0]   count;       // steps still to go
	logic               busy;
	logic               last_step;

	// one chunk of the multiplier times the shifted multiplicand
	assign partial = mcand_q * {{(2*`XLEN-STEP_W){1'b0}}, mplier_q[STEP_W-1:0]};
	assign last_step = busy && (count == CNT_W'(1));

	// bits above XLEN-1 of a negative multiplier are all ones, worth -2^XLEN
	// mcand_q << STEP_W on the last step is mcand << XLEN
	assign correction = (last_step && mplier_q[2*`XLEN-1]) ? (mcand_q << STEP_W) : '0;

	////////////////////////////////////////////////////
	// step control
	////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			busy  <= 1'b0;
			count <= '0;
			done  <= 1'b0;
		end else begin
			done <= last_step;  // one cycle, product final by then
			if (start) begin
				busy  <= 1'b1;
				count <= CNT_W'(`MULT_STEPS);
			end else if (busy) begin
				busy  <= !last_step;
				count <= count - CNT_W'(1);
			end
		end
	end

	////////////////////////////////////////////////////
	// operand and accumulator registers
	////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (start) begin
			mcand_q  <= {{`XLEN{sign[1] & mcand[`XLEN-1]}}, mcand};
			mplier_q <= {{`XLEN{sign[0] & mplier[`XLEN-1]}}, mplier};
			acc      <= '0;
		end else if (busy) begin
			acc      <= acc + partial - correction;
			mcand_q  <= mcand_q << STEP_W;
			mplier_q <= $signed(mplier_q) >>> STEP_W;  // arithmetic, top bit stays
		end
	end

	assign product = acc;

endmodule

// ==== src/pipe_pkg.sv ====
/* pipeline register layouts between issue, execute and memory
   field order is the bit order a testbench sees when it packs a record */
`include "ex_defs.svh"

package pipe_pkg;
	import isa_pkg::*;

	////////////////////////////////////////////////////
	// issue side into execute
	////////////////////////////////////////////////////
	typedef struct packed {
		logic                  valid;          // one cycle, only while not occupied
		inst_t                 inst;
		logic [`XLEN-1:0]      PC;
		logic [`XLEN-1:0]      NPC;            // PC + 4
		logic [`XLEN-1:0]      rs1_value;
		logic [`XLEN-1:0]      rs2_value;
		opa_sel_e              opa_select;
		opb_sel_e              opb_select;
		alu_func_e             alu_func;
		logic                  cond_branch;
		logic                  uncond_branch;  // jal / jalr
		logic                  rd_mem;
		logic                  wr_mem;
		logic                  csr_op;         // carried, never executed here
		logic                  halt;
		logic                  illegal;
		logic [`PRF_IDX_W-1:0] dest_prf_idx;
		logic [`ROB_IDX_W-1:0] rob_idx;
	} id_ex_packet_t;

	////////////////////////////////////////////////////
	// execute completion toward memory / writeback
	////////////////////////////////////////////////////
	typedef struct packed {
		logic                  valid;          // one cycle per completed op
		logic [`XLEN-1:0]      alu_result;
		logic                  take_branch;
		logic [`XLEN-1:0]      NPC;
		logic [`XLEN-1:0]      rs2_value;      // store data
		logic                  rd_mem;
		logic                  wr_mem;
		logic [2:0]            mem_size;       // funct3, bit 2 marks unsigned loads
		logic                  csr_op;
		logic                  halt;
		logic                  illegal;
		logic [`PRF_IDX_W-1:0] dest_prf_idx;
		logic [`ROB_IDX_W-1:0] rob_idx;
	} ex_mem_packet_t;

endpackage

// ==== verification/ex_checker.sv ====
/* watches the execute stage outputs on the falling edge
   expected entries are pushed by the driver on the accepting edge */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_checker (
	input logic                                 clock,
	input logic                                 reset,
	input pipe_pkg::ex_mem_packet_t [`WAYS-1:0] ex_packet_out,
	input logic [`WAYS-1:0]                     occupied
);
	import pipe_pkg::*;

	typedef struct packed {
		id_ex_packet_t issued;       // packet as accepted
		logic [31:0]   result;
		logic          take_branch;
		logic          is_mult;      // occupied must stay high until done
	} expect_t;

	expect_t exp_q0[$];
	expect_t exp_q1[$];
	int      mismatch_count = 0;
	int      other_count    = 0;

	task automatic push_expected(input int way, input id_ex_packet_t issued,
		input logic [31:0] result, input logic take_branch, input logic is_mult);
		expect_t rec;
		rec = '{issued, result, take_branch, is_mult};
		if (way == 0) exp_q0.push_back(rec);
		else          exp_q1.push_back(rec);
	endtask

	function automatic int pending_count();
		return exp_q0.size() + exp_q1.size();
	endfunction

	task automatic compare_field(input int way, input string name,
		input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected) begin
			$display("MISMATCH way %0d %s: got %h expected %h", way, name, got, expected);
			mismatch_count++;
		end
	endtask

	// result, branch and every pass-through field
	task automatic compare_completion(input int way, input ex_mem_packet_t got,
		input expect_t want);
		compare_field(way, "alu_result", got.alu_result, want.result);
		compare_field(way, "take_branch", 32'(got.take_branch), 32'(want.take_branch));
		compare_field(way, "NPC", got.NPC, want.issued.NPC);
		compare_field(way, "rs2_value", got.rs2_value, want.issued.rs2_value);
		// mem_size is the funct3 field
		compare_field(way, "mem_size", 32'(got.mem_size), 32'(want.issued.inst[14:12]));
		compare_field(way, "rd_mem", 32'(got.rd_mem), 32'(want.issued.rd_mem));
		compare_field(way, "wr_mem", 32'(got.wr_mem), 32'(want.issued.wr_mem));
		compare_field(way, "csr_op", 32'(got.csr_op), 32'(want.issued.csr_op));
		compare_field(way, "halt", 32'(got.halt), 32'(want.issued.halt));
		compare_field(way, "illegal", 32'(got.illegal), 32'(want.issued.illegal));
		compare_field(way, "rob_idx", 32'(got.rob_idx), 32'(want.issued.rob_idx));
		compare_field(way, "dest_prf_idx", 32'(got.dest_prf_idx),
			32'(want.issued.dest_prf_idx));
	endtask

	////////////////////////////////////////////////////
	// per-way check
	////////////////////////////////////////////////////
	task automatic check_way(input int w);
		ex_mem_packet_t pkt;
		expect_t        head;
		logic           has_head;
		pkt      = ex_packet_out[w];
		has_head = (w == 0) ? (exp_q0.size() > 0) : (exp_q1.size() > 0);
		head     = '0;
		if (has_head) head = (w == 0) ? exp_q0[0] : exp_q1[0];
		if (pkt.valid) begin
			if (!has_head) begin
				$display("way %0d completed with nothing outstanding at %0t", w, $time);
				other_count++;
			end else begin
				if (w == 0) void'(exp_q0.pop_front());
				else        void'(exp_q1.pop_front());
				compare_completion(w, pkt, head);
			end
		end else if (has_head && !head.is_mult) begin
			// base ops complete in the cycle right after acceptance
			$display("way %0d base op did not complete one cycle after acceptance at %0t",
				w, $time);
			other_count++;
		end else if (has_head && !occupied[w]) begin
			$display("way %0d dropped occupied during a multiply at %0t", w, $time);
			other_count++;
		end else if (!has_head && occupied[w]) begin
			$display("way %0d occupied with nothing outstanding at %0t", w, $time);
			other_count++;
		end
	endtask

	always @(negedge clock) begin
		if (!reset) begin
			check_way(0);
			check_way(1);
		end
	end

endmodule

// ==== verification/ex_patterns.hex ====
// way inst pc rs1 rs2 ctrl rob result take, ctrl digits: opa opb func {cond,uncond}
// way 0 base ops and multiplies, way 1 operand sources and branches
0 00000000 00000000 00000005 00000007 0000 01 0000000c 0
0 00000000 00000000 00000005 00000007 0010 02 fffffffe 0
0 00000000 00000000 ffffffff 00000001 0020 03 00000001 0
0 00000000 00000000 ffffffff 00000001 0030 04 00000000 0
0 00000000 00000000 f0f0f0f0 ff00ff00 0040 05 f000f000 0
0 00000000 00000000 f0f0f0f0 0f0f0000 0050 06 fffff0f0 0
0 00000000 00000000 aaaaaaaa ffffffff 0060 07 55555555 0
0 00000000 00000000 00000001 0000001f 0070 08 80000000 0
0 00000000 00000000 00000003 00000021 0070 09 00000006 0
0 00000000 00000000 80000000 0000001f 0080 0a 00000001 0
0 00000000 00000000 80000000 0000003f 0090 0b ffffffff 0
0 00000000 00000000 ffffffff ffffffff 00a0 0c 00000001 0
0 00000000 00000000 ffffffff ffffffff 00b0 0d 00000000 0
0 00000000 00000000 80000000 80000000 00b0 0e 40000000 0
0 00000000 00000000 ffffffff ffffffff 00c0 0f ffffffff 0
0 00000000 00000000 ffffffff ffffffff 00d0 10 fffffffe 0
0 00000000 00000000 7fffffff 00000003 00a0 11 7ffffffd 0
0 00000000 00000000 00000000 deadbeef 3000 12 deadbeef 0
0 00000000 00000000 00000002 ffffffff 00c0 13 00000001 0
0 00000000 00000000 ffffffff 00000002 00b0 14 ffffffff 0
1 00000000 00001000 00000000 00000004 2000 15 00001004 0
1 00000000 00001000 00000000 00000000 1000 16 00001004 0
1 12345037 00000000 00000000 00000000 3400 17 12345000 0
1 fff00013 00000000 00000010 00000000 0100 18 0000000f 0
1 fe000c23 00000000 00000100 00000000 0200 19 000000f8 0
1 00000863 00002000 00000005 00000005 2302 1a 00002010 1
1 0080006f 00003000 00000000 00000000 2501 1b 00003008 1
1 00001863 00004000 00000005 00000005 2302 1c 00004010 0
1 00004863 00004000 ffffffff 00000001 2302 1d 00004010 1
1 00005863 00004000 ffffffff 00000001 2302 1e 00004010 0
1 00006863 00004000 ffffffff 00000001 2302 1f 00004010 0
1 00007863 00004000 ffffffff 00000001 2302 00 00004010 1
1 00000863 00004000 00000001 00000002 2302 01 00004010 0
1 00000000 00000000 00010000 00010000 00d0 02 00000001 0
1 00000000 00000000 00000005 00000003 0010 03 00000002 0
1 fff00067 00005000 00000100 00000000 0101 04 000000ff 1
// end marker
ffffffff 0 0 0 0 0 0 0 0

// ==== verification/ex_stage_tb.sv ====
/* testbench for the two-way execute stage, run from the project root
   records in verification/ex_patterns.hex end with a way word of ffffffff
   dest_prf_idx and the memory/status flags follow rob_idx, NPC is always PC + 4 */
`timescale 1ns/100ps
`include "ex_defs.svh"

module ex_stage_tb;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int REC_WORDS = 9;    // way inst pc rs1 rs2 ctrl rob result take
	localparam int MAX_RECS  = 64;

	logic                       clock;
	logic                       reset;
	id_ex_packet_t  [`WAYS-1:0] id_ex_packet_in;
	ex_mem_packet_t [`WAYS-1:0] ex_packet_out;
	logic [`WAYS-1:0]           occupied;

	logic [31:0] pattern_mem [0:REC_WORDS*MAX_RECS-1];
	int          num_recs;
	int          timeout_limit = 0;
	int          cycle_count   = 0;

	ex_stage ex_stage_inst (
		.clock           (clock),
		.reset           (reset),
		.id_ex_packet_in (id_ex_packet_in),
		.ex_packet_out   (ex_packet_out),
		.occupied        (occupied)
	);

	ex_checker monitor_inst (
		.clock         (clock),
		.reset         (reset),
		.ex_packet_out (ex_packet_out),
		.occupied      (occupied)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;  // 20 ns
	end

	////////////////////////////////////////////////////
	// record to issue packet
	////////////////////////////////////////////////////
	function automatic id_ex_packet_t build_packet(input int r);
		id_ex_packet_t pkt;
		logic [31:0]   ctrl;
		int            base;
		base = r * REC_WORDS;
		ctrl = pattern_mem[base+5];
		pkt               = '0;
		pkt.valid         = 1'b1;
		pkt.inst          = pattern_mem[base+1];
		pkt.PC            = pattern_mem[base+2];
		pkt.NPC           = pattern_mem[base+2] + 32'd4;
		pkt.rs1_value     = pattern_mem[base+3];
		pkt.rs2_value     = pattern_mem[base+4];
		pkt.opa_select    = opa_sel_e'(ctrl[13:12]);  // hex digit 3
		pkt.opb_select    = opb_sel_e'(ctrl[10:8]);   // hex digit 2
		pkt.alu_func      = alu_func_e'(ctrl[7:4]);   // hex digit 1
		pkt.cond_branch   = ctrl[1];
		pkt.uncond_branch = ctrl[0];
		pkt.rob_idx       = pattern_mem[base+6][4:0];
		pkt.dest_prf_idx  = {1'b1, pattern_mem[base+6][4:0]};
		// flags follow the rob tag bits so each one toggles
		{pkt.rd_mem, pkt.wr_mem, pkt.csr_op, pkt.halt, pkt.illegal} = pattern_mem[base+6][4:0];
		return pkt;
	endfunction

	// issues every record of one way in file order
	task automatic drive_way(input int w);
		id_ex_packet_t pkt;
		int            idle;
		logic [3:0]    func;
		for (int r = 0; r < num_recs; r++) begin
			if (pattern_mem[r*REC_WORDS] == w) begin
				pkt  = build_packet(r);
				func = pattern_mem[r*REC_WORDS+5][7:4];
				idle = int'($urandom % 3);
				repeat (idle) begin
					@(posedge clock);
					#2;
				end
				while (occupied[w]) begin  // wait out a running multiply
					@(posedge clock);
					#2;
				end
				id_ex_packet_in[w] = pkt;
				@(posedge clock);  // accepted here
				monitor_inst.push_expected(w, pkt, pattern_mem[r*REC_WORDS+7],
					pattern_mem[r*REC_WORDS+8][0], (func >= 4'ha) && (func <= 4'hd));
				#2;
				id_ex_packet_in[w].valid = 1'b0;
			end
		end
	endtask

	////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////
	initial begin
		void'($urandom(32'h1a2e_e5c1));
		reset           = 1'b1;
		id_ex_packet_in = '0;
		$readmemh("verification/ex_patterns.hex", pattern_mem);
		num_recs = 0;
		while (num_recs < MAX_RECS && pattern_mem[num_recs*REC_WORDS] != 32'hffff_ffff)
			num_recs++;
		timeout_limit = num_recs * (`MULT_STEPS + 4) + 200;
		repeat (16) @(posedge clock);
		#2;
		reset = 1'b0;
		repeat (3) begin  // idle window with nothing to complete
			@(posedge clock);
			#2;
		end
		fork
			drive_way(0);
			drive_way(1);
		join
		while (monitor_inst.pending_count() != 0) @(posedge clock);
		repeat (4) @(posedge clock);
		$display("%0d records, %0d mismatches, %0d other errors", num_recs,
			monitor_inst.mismatch_count, monitor_inst.other_count);
		if (monitor_inst.mismatch_count + monitor_inst.other_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// watchdog
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			$display("timeout after %0d cycles, %0d expected completions still pending",
				cycle_count, monitor_inst.pending_count());
			$display("%0d records, %0d mismatches, %0d other errors", num_recs,
				monitor_inst.mismatch_count, monitor_inst.other_count + 1);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

endmodule
